//--- Bender.yml
package:
  name: link_test

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/pkt_pkg.sv
      - hw/pkt_source.sv
      - hw/link_hop.sv
      - hw/pkt_checker.sv
      - hw/switch_debounce.sv
      - hw/seg7_display.sv
      - hw/link_test_top.sv

  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/tb_link_test.sv

//--- hw/link_hop.sv
`timescale 1ns/100ps

`include "link_test_config.svh"

module link_hop (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  pkt_pkg::pkt_t         i_pkt,
	input  logic                  i_valid,
	output logic                  o_ready,
	input  pkt_pkg::fault_kind_e  i_fault,
	output pkt_pkg::pkt_t         o_pkt,
	output logic                  o_valid,
	input  logic                  i_ready
);

	pkt_pkg::pkt_t        r_main;
	pkt_pkg::pkt_t        r_spare;
	logic                 r_main_valid;
	logic                 r_spare_valid;
	pkt_pkg::fault_kind_e r_armed;
	pkt_pkg::pkt_t        w_in_pkt;
	logic                 w_accept;
	logic                 w_main_load;

	assign w_accept    = i_valid & o_ready;
	// main register can take a new beat this cycle
	assign w_main_load = ~r_main_valid | i_ready;

	// corruption applied on the way in, redun left as sent
	always_comb begin
		w_in_pkt = i_pkt;
		case (r_armed)
			pkt_pkg::FAULT_DATA: w_in_pkt.data[0] = ~i_pkt.data[0];
			pkt_pkg::FAULT_ADDR: w_in_pkt.addr[`LT_ADDR_W-1] = 1'b1;
			default: w_in_pkt = i_pkt;
		endcase
	end

	// one-shot latch, a fresh request overrides
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_armed <= pkt_pkg::FAULT_NONE;
		end else if (i_fault != pkt_pkg::FAULT_NONE) begin
			r_armed <= i_fault;
		end else if (w_accept) begin
			r_armed <= pkt_pkg::FAULT_NONE;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_main_valid  <= 1'b0;
			r_spare_valid <= 1'b0;
		end else if (w_main_load) begin
			// spare drains first to keep order
			if (r_spare_valid) begin
				r_main_valid  <= 1'b1;
				r_spare_valid <= 1'b0;
			end else begin
				r_main_valid <= w_accept;
			end
		end else if (w_accept) begin
			r_spare_valid <= 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (w_main_load) begin
			r_main <= r_spare_valid ? r_spare : w_in_pkt;
		end else if (w_accept) begin
			r_spare <= w_in_pkt;
		end
	end

	// ready straight from a flop, high while the spare is empty
	assign o_ready = ~r_spare_valid;
	assign o_pkt   = r_main;
	assign o_valid = r_main_valid;

endmodule

//--- hw/link_test_config.svh
`ifndef LINK_TEST_CONFIG_SVH
`define LINK_TEST_CONFIG_SVH

// packet field widths
`define LT_ADDR_W 8
`define LT_DATA_W 16
`define LT_RED_W 8

// sequence number and good counter width
`define LT_SEQ_W 16

// register hops between source and checker
`define LT_NUM_HOPS 3
`define LT_HOP_IDX_W 2

// legal address window, source wraps inside it
`define LT_MIN_ADDR 0
`define LT_MAX_ADDR 55

// stable samples before a switch level is taken
`define LT_DEBOUNCE_CYCLES 4

// one hex digit, segments g down to a
`define LT_SEG_W 7

`endif

//--- hw/link_test_top.sv
`timescale 1ns/100ps

`include "link_test_config.svh"

module link_test_top (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic                      i_switch,
	input  logic                      i_pause,
	input  logic                      i_clear,
	input  pkt_pkg::fault_kind_e      i_fault_kind,
	input  logic [`LT_HOP_IDX_W-1:0]  i_fault_hop,
	output logic [`LT_SEQ_W-1:0]      o_good_count,
	output logic                      o_err_redun,
	output logic                      o_err_range,
	output logic                      o_err_seq,
	output pkt_pkg::first_err_t       o_first_err,
	output logic [`LT_SEG_W-1:0]      o_seg_hi,
	output logic [`LT_SEG_W-1:0]      o_seg_lo
);

	// link k feeds hop k, the last link feeds the checker
	pkt_pkg::pkt_t        lnk_pkt   [0:`LT_NUM_HOPS];
	logic                 lnk_valid [0:`LT_NUM_HOPS];
	logic                 lnk_ready [0:`LT_NUM_HOPS];
	pkt_pkg::fault_kind_e hop_fault [0:`LT_NUM_HOPS-1];

	logic w_press;
	logic w_any_err;

	pkt_source u_source (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.o_pkt   (lnk_pkt[0]),
		.o_valid (lnk_valid[0]),
		.i_ready (lnk_ready[0])
	);

	for (genvar k = 0; k < `LT_NUM_HOPS; k++) begin : g_hop
		// only the addressed hop sees the request
		assign hop_fault[k] = (i_fault_hop == `LT_HOP_IDX_W'(k)) ? i_fault_kind
		                                                        : pkt_pkg::FAULT_NONE;

		link_hop u_hop (
			.i_clk   (i_clk),
			.i_rst_n (i_rst_n),
			.i_pkt   (lnk_pkt[k]),
			.i_valid (lnk_valid[k]),
			.o_ready (lnk_ready[k]),
			.i_fault (hop_fault[k]),
			.o_pkt   (lnk_pkt[k+1]),
			.o_valid (lnk_valid[k+1]),
			.i_ready (lnk_ready[k+1])
		);
	end

	pkt_checker u_checker (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_clear      (i_clear),
		.i_pause      (i_pause),
		.i_pkt        (lnk_pkt[`LT_NUM_HOPS]),
		.i_valid      (lnk_valid[`LT_NUM_HOPS]),
		.o_ready      (lnk_ready[`LT_NUM_HOPS]),
		.o_good_count (o_good_count),
		.o_err_redun  (o_err_redun),
		.o_err_range  (o_err_range),
		.o_err_seq    (o_err_seq),
		.o_first_err  (o_first_err)
	);

	assign w_any_err = o_err_redun | o_err_range | o_err_seq;

	switch_debounce u_debounce (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_switch (i_switch),
		.o_press  (w_press)
	);

	seg7_display u_display (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_press      (w_press),
		.i_good_count (o_good_count),
		.i_any_err    (w_any_err),
		.i_first_err  (o_first_err),
		.o_seg_hi     (o_seg_hi),
		.o_seg_lo     (o_seg_lo)
	);

endmodule

//--- hw/pkt_checker.sv
`timescale 1ns/100ps

`include "link_test_config.svh"

module pkt_checker (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_clear,
	input  logic                  i_pause,
	input  pkt_pkg::pkt_t         i_pkt,
	input  logic                  i_valid,
	output logic                  o_ready,
	output logic [`LT_SEQ_W-1:0]  o_good_count,
	output logic                  o_err_redun,
	output logic                  o_err_range,
	output logic                  o_err_seq,
	output pkt_pkg::first_err_t   o_first_err
);

	localparam logic [`LT_ADDR_W-1:0] MIN_ADDR = `LT_MIN_ADDR;
	localparam logic [`LT_ADDR_W-1:0] MAX_ADDR = `LT_MAX_ADDR;

	logic [`LT_SEQ_W-1:0] r_exp_seq;
	logic                 r_synced;
	logic [`LT_SEQ_W-1:0] r_good_count;
	logic                 r_err_redun;
	logic                 r_err_range;
	logic                 r_err_seq;
	pkt_pkg::first_err_t  r_first_err;

	logic                 w_accept;
	logic                 w_redun_bad;
	logic                 w_range_bad;
	logic                 w_seq_bad;
	logic [`LT_SEQ_W-1:0] w_seq_ref;
	logic [`LT_SEQ_W-1:0] w_next_seq;
	pkt_pkg::err_kind_e   w_kind;

	assign o_ready  = ~i_pause;
	assign w_accept = i_valid & o_ready;

	assign w_redun_bad = pkt_pkg::calc_redun(i_pkt.addr, i_pkt.data) != i_pkt.redun;
	assign w_range_bad = (i_pkt.addr < MIN_ADDR) || (i_pkt.addr > MAX_ADDR);
	// data is only trusted for sequencing when redun holds
	assign w_seq_bad   = r_synced && !w_redun_bad && (i_pkt.data != r_exp_seq);

	// after a clear the first packet sets the reference
	assign w_seq_ref  = r_synced ? r_exp_seq : i_pkt.data;
	assign w_next_seq = (w_redun_bad && r_synced) ? r_exp_seq + 1'b1 : i_pkt.data + 1'b1;

	always_comb begin
		if (w_redun_bad) begin
			w_kind = pkt_pkg::ERR_REDUN;
		end else if (w_range_bad) begin
			w_kind = pkt_pkg::ERR_RANGE;
		end else if (w_seq_bad) begin
			w_kind = pkt_pkg::ERR_SEQ;
		end else begin
			w_kind = pkt_pkg::ERR_NONE;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_exp_seq    <= '0;
			r_synced     <= 1'b1;
			r_good_count <= '0;
			r_err_redun  <= 1'b0;
			r_err_range  <= 1'b0;
			r_err_seq    <= 1'b0;
			r_first_err  <= '0;
		end else if (i_clear) begin
			r_synced     <= 1'b0;
			r_good_count <= '0;
			r_err_redun  <= 1'b0;
			r_err_range  <= 1'b0;
			r_err_seq    <= 1'b0;
			r_first_err  <= '0;
		end else if (w_accept) begin
			r_exp_seq <= w_next_seq;
			r_synced  <= 1'b1;
			if (w_kind == pkt_pkg::ERR_NONE) begin
				r_good_count <= r_good_count + 1'b1;
			end else begin
				r_err_redun <= r_err_redun | w_redun_bad;
				r_err_range <= r_err_range | w_range_bad;
				r_err_seq   <= r_err_seq | w_seq_bad;
				// capture only once until cleared
				if (r_first_err.kind == pkt_pkg::ERR_NONE) begin
					r_first_err.kind <= w_kind;
					r_first_err.seq  <= w_seq_ref;
					r_first_err.addr <= i_pkt.addr;
					r_first_err.data <= i_pkt.data;
				end
			end
		end
	end

	assign o_good_count = r_good_count;
	assign o_err_redun  = r_err_redun;
	assign o_err_range  = r_err_range;
	assign o_err_seq    = r_err_seq;
	assign o_first_err  = r_first_err;

endmodule

//--- hw/pkt_pkg.sv
`include "link_test_config.svh"

package pkt_pkg;

	// one beat on a packet link
	typedef struct packed {
		logic [`LT_ADDR_W-1:0] addr;
		logic [`LT_DATA_W-1:0] data;
		logic [`LT_RED_W-1:0]  redun;
	} pkt_t;

	// corruption a hop applies to the next accepted packet
	typedef enum logic [1:0] {
		FAULT_NONE = 2'd0,
		FAULT_DATA = 2'd1,
		FAULT_ADDR = 2'd2
	} fault_kind_e;

	// listed in checking priority
	typedef enum logic [1:0] {
		ERR_NONE  = 2'd0,
		ERR_REDUN = 2'd1,
		ERR_RANGE = 2'd2,
		ERR_SEQ   = 2'd3
	} err_kind_e;

	// snapshot of the first failing packet
	typedef struct packed {
		err_kind_e             kind;
		logic [`LT_SEQ_W-1:0]  seq;
		logic [`LT_ADDR_W-1:0] addr;
		logic [`LT_DATA_W-1:0] data;
	} first_err_t;

	// xor of the address with both data bytes
	function automatic logic [`LT_RED_W-1:0] calc_redun(
		input logic [`LT_ADDR_W-1:0] addr,
		input logic [`LT_DATA_W-1:0] data
	);
		return addr ^ data[`LT_DATA_W-1:8] ^ data[7:0];
	endfunction

endpackage

//--- hw/pkt_source.sv
`timescale 1ns/100ps

`include "link_test_config.svh"

module pkt_source (
	input  logic            i_clk,
	input  logic            i_rst_n,
	output pkt_pkg::pkt_t   o_pkt,
	output logic            o_valid,
	input  logic            i_ready
);

	localparam logic [`LT_ADDR_W-1:0] MIN_ADDR = `LT_MIN_ADDR;
	localparam logic [`LT_ADDR_W-1:0] MAX_ADDR = `LT_MAX_ADDR;

	logic [`LT_SEQ_W-1:0]  r_seq;
	logic [`LT_ADDR_W-1:0] r_addr;
	logic                  r_valid;
	logic                  w_fire;

	assign w_fire = r_valid & i_ready;

	// stream never ends, valid stays high once out of reset
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_valid <= 1'b0;
		end else begin
			r_valid <= 1'b1;
		end
	end

	// counters only move on a transfer so a stalled beat holds
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_seq  <= '0;
			r_addr <= MIN_ADDR;
		end else if (w_fire) begin
			r_seq <= r_seq + 1'b1;
			if (r_addr == MAX_ADDR) begin
				r_addr <= MIN_ADDR;
			end else begin
				r_addr <= r_addr + 1'b1;
			end
		end
	end

	assign o_valid     = r_valid;
	assign o_pkt.addr  = r_addr;
	assign o_pkt.data  = r_seq;
	assign o_pkt.redun = pkt_pkg::calc_redun(r_addr, r_seq);

endmodule

//--- hw/seg7_display.sv
`timescale 1ns/100ps

`include "link_test_config.svh"

module seg7_display (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_press,
	input  logic [`LT_SEQ_W-1:0]  i_good_count,
	input  logic                  i_any_err,
	input  pkt_pkg::first_err_t   i_first_err,
	output logic [`LT_SEG_W-1:0]  o_seg_hi,
	output logic [`LT_SEG_W-1:0]  o_seg_lo
);

	logic [`LT_SEG_W-1:0] r_seg_hi;
	logic [`LT_SEG_W-1:0] r_seg_lo;
	logic [3:0]           w_nib_hi;
	logic [3:0]           w_nib_lo;

	// hex digit to segments g..a, a zero bit lights the segment
	function automatic logic [`LT_SEG_W-1:0] hex_to_seg(input logic [3:0] nib);
		case (nib)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'ha: return 7'b0001000;
			4'hb: return 7'b0000011;
			4'hc: return 7'b1000110;
			4'hd: return 7'b0100001;
			4'he: return 7'b0000110;
			default: return 7'b0001110;
		endcase
	endfunction

	// error view shows address and data, otherwise the count byte
	always_comb begin
		if (i_any_err) begin
			w_nib_hi = i_first_err.addr[3:0];
			w_nib_lo = i_first_err.data[3:0];
		end else begin
			w_nib_hi = i_good_count[7:4];
			w_nib_lo = i_good_count[3:0];
		end
	end

	// blank until the first press
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_seg_hi <= '1;
			r_seg_lo <= '1;
		end else if (i_press) begin
			r_seg_hi <= hex_to_seg(w_nib_hi);
			r_seg_lo <= hex_to_seg(w_nib_lo);
		end
	end

	assign o_seg_hi = r_seg_hi;
	assign o_seg_lo = r_seg_lo;

endmodule

//--- hw/switch_debounce.sv
`timescale 1ns/100ps

`include "link_test_config.svh"

module switch_debounce (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_switch,
	output logic o_press
);

	localparam int CNT_W = $clog2(`LT_DEBOUNCE_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`LT_DEBOUNCE_CYCLES - 1);

	logic [CNT_W-1:0] r_cnt;
	logic             r_level;
	logic             r_level_d;
	logic             r_press;

	// level only changes after enough samples that disagree with it
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_cnt   <= '0;
			r_level <= 1'b0;
		end else if (i_switch != r_level) begin
			if (r_cnt == CNT_LAST) begin
				r_level <= i_switch;
				r_cnt   <= '0;
			end else begin
				r_cnt <= r_cnt + 1'b1;
			end
		end else begin
			r_cnt <= '0;
		end
	end

	// rising edge of the filtered level
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			r_level_d <= 1'b0;
			r_press   <= 1'b0;
		end else begin
			r_level_d <= r_level;
			r_press   <= r_level & ~r_level_d;
		end
	end

	assign o_press = r_press;

endmodule

//--- project.f
+incdir+hw
hw/pkt_pkg.sv
hw/pkt_source.sv
hw/link_hop.sv
hw/pkt_checker.sv
hw/switch_debounce.sv
hw/seg7_display.sv
hw/link_test_top.sv
verif/tb_link_test.sv

//--- verif/tb_link_test.sv
`timescale 1ns/100ps

`include "link_test_config.svh"

module tb_link_test;

	localparam int NUM_ROWS    = 7;
	localparam int ADDR_SPAN   = `LT_MAX_ADDR - `LT_MIN_ADDR + 1;
	// row cycle at which the fault request is raised, well after the resync
	localparam int FAULT_CYCLE = 12;
	localparam int CLOCK_HALF  = 5;

	typedef struct packed {
		logic [7:0]                   pause_pct;
		logic [`LT_HOP_IDX_W-1:0]     fault_hop;
		pkt_pkg::fault_kind_e         fault_kind;
		logic [15:0]                  cycles;
		logic                         exp_redun;
		logic                         exp_range;
		logic                         exp_seq;
	} row_t;

	// pause %, hop, fault, cycles, expected redun/range/seq flags
	localparam row_t TEST_TABLE [0:NUM_ROWS-1] = '{
		'{8'd0,  2'd0, pkt_pkg::FAULT_NONE, 16'd60,  1'b0, 1'b0, 1'b0},
		'{8'd40, 2'd0, pkt_pkg::FAULT_NONE, 16'd120, 1'b0, 1'b0, 1'b0},
		'{8'd0,  2'd1, pkt_pkg::FAULT_DATA, 16'd60,  1'b1, 1'b0, 1'b0},
		'{8'd25, 2'd2, pkt_pkg::FAULT_ADDR, 16'd80,  1'b1, 1'b1, 1'b0},
		'{8'd0,  2'd0, pkt_pkg::FAULT_DATA, 16'd50,  1'b1, 1'b0, 1'b0},
		'{8'd0,  2'd0, pkt_pkg::FAULT_ADDR, 16'd50,  1'b1, 1'b1, 1'b0},
		'{8'd60, 2'd1, pkt_pkg::FAULT_NONE, 16'd80,  1'b0, 1'b0, 1'b0}
	};

	logic                      i_clk;
	logic                      i_rst_n;
	logic                      i_switch;
	logic                      i_pause;
	logic                      i_clear;
	pkt_pkg::fault_kind_e      i_fault_kind;
	logic [`LT_HOP_IDX_W-1:0]  i_fault_hop;
	logic [`LT_SEQ_W-1:0]      o_good_count;
	logic                      o_err_redun;
	logic                      o_err_range;
	logic                      o_err_seq;
	pkt_pkg::first_err_t       o_first_err;
	logic [`LT_SEG_W-1:0]      o_seg_hi;
	logic [`LT_SEG_W-1:0]      o_seg_lo;

	int          error_count;
	int          cycle_count;
	int          timeout_limit;
	logic [15:0] frozen_count;
	logic [7:0]  err_addr;
	logic [15:0] err_data;
	logic [3:0]  nib_hi;
	logic [3:0]  nib_lo;

	link_test_top dut0 (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_switch     (i_switch),
		.i_pause      (i_pause),
		.i_clear      (i_clear),
		.i_fault_kind (i_fault_kind),
		.i_fault_hop  (i_fault_hop),
		.o_good_count (o_good_count),
		.o_err_redun  (o_err_redun),
		.o_err_range  (o_err_range),
		.o_err_seq    (o_err_seq),
		.o_first_err  (o_first_err),
		.o_seg_hi     (o_seg_hi),
		.o_seg_lo     (o_seg_lo)
	);

	always #CLOCK_HALF i_clk = ~i_clk;

	task automatic stop_failed();
		error_count++;
		$display("Simulation finished: FAIL");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_problem(input string msg);
		$display("%s", msg);
		stop_failed();
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected 0x%0h, got 0x%0h", name, expected, actual);
			stop_failed();
		end
	endtask

	// stream rule, address walks the legal window with the packet number
	function automatic logic [7:0] stream_addr(input logic [15:0] n);
		return 8'(`LT_MIN_ADDR + (n % ADDR_SPAN));
	endfunction

	function automatic logic [7:0] model_addr(input pkt_pkg::fault_kind_e kind,
			input logic [15:0] n);
		logic [7:0] a;
		a = stream_addr(n);
		if (kind == pkt_pkg::FAULT_ADDR) begin
			a[7] = 1'b1;
		end
		return a;
	endfunction

	function automatic logic [15:0] model_data(input pkt_pkg::fault_kind_e kind,
			input logic [15:0] n);
		logic [15:0] d;
		d = n;
		if (kind == pkt_pkg::FAULT_DATA) begin
			d[0] = ~d[0];
		end
		return d;
	endfunction

	// lit segments gfedcba per hex digit, inverted for the active-low pins
	function automatic logic [6:0] hex_segments(input logic [3:0] nib);
		logic [6:0] lit [0:15];
		lit = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
		        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};
		return ~lit[nib];
	endfunction

	function automatic int table_cycles();
		int total;
		total = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			total += TEST_TABLE[r].cycles;
		end
		return total;
	endfunction

	task automatic run_row(input row_t row);
		logic [15:0] prev;
		logic [15:0] delta;
		int unsigned unpaused;
		int unsigned slack;
		int unsigned low_bound;
		logic        pause_now;
		prev     = '0;
		unpaused = 0;
		for (int c = 0; c < row.cycles; c++) begin
			@(posedge i_clk);
			pause_now = (($urandom % 100) < row.pause_pct);
			if (!pause_now) begin
				unpaused++;
			end
			i_pause      <= pause_now;
			i_fault_hop  <= row.fault_hop;
			i_fault_kind <= (c == FAULT_CYCLE) ? row.fault_kind : pkt_pkg::FAULT_NONE;
			@(negedge i_clk);
			delta = o_good_count - prev;
			if (delta > 16'd1) begin
				report_problem($sformatf("good count jumped from %0d to %0d",
					prev, o_good_count));
			end
			check_value("o_err_seq", o_err_seq, 1'b0);
			if (row.fault_kind == pkt_pkg::FAULT_NONE) begin
				check_value("o_err_redun", o_err_redun, 1'b0);
				check_value("o_err_range", o_err_range, 1'b0);
			end
			prev = o_good_count;
		end
		// pipeline fill plus one lost beat for a corrupted packet
		slack     = `LT_NUM_HOPS + 2 + ((row.fault_kind == pkt_pkg::FAULT_NONE) ? 0 : 1);
		low_bound = (unpaused > slack) ? unpaused - slack : 0;
		if (o_good_count < low_bound || o_good_count > row.cycles) begin
			report_problem($sformatf("good count %0d outside %0d..%0d after %0d cycles",
				o_good_count, low_bound, row.cycles, row.cycles));
		end
	endtask

	task automatic check_row_end(input row_t row);
		pkt_pkg::first_err_t fe;
		fe = o_first_err;
		check_value("o_err_redun", o_err_redun, row.exp_redun);
		check_value("o_err_range", o_err_range, row.exp_range);
		check_value("o_err_seq", o_err_seq, row.exp_seq);
		if (row.fault_kind == pkt_pkg::FAULT_NONE) begin
			check_value("o_first_err.kind", fe.kind, pkt_pkg::ERR_NONE);
		end else begin
			check_value("o_first_err.kind", fe.kind, pkt_pkg::ERR_REDUN);
			check_value("o_first_err.addr", fe.addr, model_addr(row.fault_kind, fe.seq));
			check_value("o_first_err.data", fe.data, model_data(row.fault_kind, fe.seq));
		end
	endtask

	// stop the checker so the count stays put during the press
	task automatic hold_pause();
		@(posedge i_clk);
		i_pause      <= 1'b1;
		i_fault_kind <= pkt_pkg::FAULT_NONE;
		repeat (2) @(posedge i_clk);
		@(negedge i_clk);
	endtask

	task automatic press_and_check(input logic [3:0] hi, input logic [3:0] lo);
		@(posedge i_clk);
		i_switch <= 1'b1;
		repeat (6) @(posedge i_clk);
		i_switch <= 1'b0;
		@(negedge i_clk);
		check_value("o_seg_hi", o_seg_hi, hex_segments(hi));
		check_value("o_seg_lo", o_seg_lo, hex_segments(lo));
	endtask

	task automatic clear_and_check();
		@(posedge i_clk);
		i_clear <= 1'b1;
		i_pause <= 1'b0;
		@(posedge i_clk);
		i_clear <= 1'b0;
		@(negedge i_clk);
		check_value("o_err_redun", o_err_redun, 1'b0);
		check_value("o_err_range", o_err_range, 1'b0);
		check_value("o_err_seq", o_err_seq, 1'b0);
		check_value("o_first_err", o_first_err, '0);
		check_value("o_good_count", o_good_count, '0);
	endtask

	always @(posedge i_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			report_problem($sformatf("timeout: run still going after %0d cycles",
				cycle_count));
		end
	end

	initial begin
		i_clk         = 1'b0;
		i_rst_n       = 1'b0;
		i_switch      = 1'b0;
		i_pause       = 1'b0;
		i_clear       = 1'b0;
		i_fault_kind  = pkt_pkg::FAULT_NONE;
		i_fault_hop   = '0;
		error_count   = 0;
		cycle_count   = 0;
		void'($urandom(96));
		timeout_limit = table_cycles() + 200;

		repeat (3) @(posedge i_clk);
		i_rst_n <= 1'b1;

		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(TEST_TABLE[r]);
			check_row_end(TEST_TABLE[r]);
			hold_pause();
			frozen_count = o_good_count;
			if (TEST_TABLE[r].fault_kind == pkt_pkg::FAULT_NONE) begin
				nib_hi = frozen_count[7:4];
				nib_lo = frozen_count[3:0];
			end else begin
				err_addr = model_addr(TEST_TABLE[r].fault_kind, o_first_err.seq);
				err_data = model_data(TEST_TABLE[r].fault_kind, o_first_err.seq);
				nib_hi   = err_addr[3:0];
				nib_lo   = err_data[3:0];
			end
			press_and_check(nib_hi, nib_lo);
			check_value("o_good_count", o_good_count, frozen_count);
			clear_and_check();
		end

		if (error_count == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("Simulation finished: FAIL");
			$fatal(1, "errors were found");
		end
	end

endmodule
